/* Bender.yml */
package:
  name: rr_record

sources:
  # Record path RTL, in compile order
  - files:
      - verilog/rr_pkg.sv
      - verilog/rr_pipe.sv
      - verilog/rr_axil_recorder.sv
      - verilog/rr_log_merge.sv
      - verilog/rr_trace_fifo.sv
      - verilog/rr_csrs.sv
      - verilog/rr_record_top.sv
  # Testbench and bound assertions
  - target: test
    files:
      - bench/rr_record_assertions.sv
      - bench/rr_record_tb.sv

/* all.f */
verilog/rr_pkg.sv
verilog/rr_pipe.sv
verilog/rr_axil_recorder.sv
verilog/rr_log_merge.sv
verilog/rr_trace_fifo.sv
verilog/rr_csrs.sv
verilog/rr_record_top.sv
bench/rr_record_assertions.sv
bench/rr_record_tb.sv

/* bench/rr_record_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_record_assertions
  import rr_pkg::*;
(
  input wire              i_clk,
  input wire              i_arst_n,
  // Channel ports, inbound and forwarded copies
  input wire axil_req_t   i_ocl_req,
  input wire axil_req_t   i_ocl_req_fwd,
  input wire axil_rsp_t   i_ocl_rsp,
  input wire axil_rsp_t   i_ocl_rsp_fwd,
  input wire axil_req_t   i_sda_req,
  input wire axil_req_t   i_sda_req_fwd,
  input wire axil_rsp_t   i_sda_rsp,
  input wire axil_rsp_t   i_sda_rsp_fwd,
  // Trace sink
  input wire              i_trace_valid,
  input wire trace_word_t i_trace_word,
  input wire              i_trace_ready
);

  // Word and valid hold while the sink stalls
  a_stall_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_trace_valid && !i_trace_ready) |=> (i_trace_valid && $stable(i_trace_word)))
  else $error("Trace word or valid changed while the sink stalled");

  // Nothing offered to the sink in reset
  a_reset_idle: assert property (@(posedge i_clk) !i_arst_n |-> !i_trace_valid)
  else $error("Trace valid high during reset");

  // Recorder is transparent in both directions
  a_pass_through: assert property (@(posedge i_clk)
    (i_ocl_req_fwd == i_ocl_req) && (i_ocl_rsp_fwd == i_ocl_rsp) &&
    (i_sda_req_fwd == i_sda_req) && (i_sda_rsp_fwd == i_sda_rsp))
  else $error("Forwarded channel differs from its input");

endmodule

bind rr_record_top rr_record_assertions i_assertions (
  .i_clk         (i_clk),
  .i_arst_n      (i_arst_n),
  .i_ocl_req     (i_ocl_req),
  .i_ocl_req_fwd (o_ocl_req),
  .i_ocl_rsp     (i_ocl_rsp),
  .i_ocl_rsp_fwd (o_ocl_rsp),
  .i_sda_req     (i_sda_req),
  .i_sda_req_fwd (o_sda_req),
  .i_sda_rsp     (i_sda_rsp),
  .i_sda_rsp_fwd (o_sda_rsp),
  .i_trace_valid (o_trace_valid),
  .i_trace_word  (o_trace_word),
  .i_trace_ready (i_trace_ready)
);

`default_nettype wire

/* bench/rr_record_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_record_tb
  import rr_pkg::*;
();

  localparam int MODE_STAGES   = 4;
  localparam int FIFO_DEPTH    = 8;
  localparam int CHECK_W       = 512;
  // Phase lengths in cycles
  localparam int OFF_CYCLES    = 200;
  localparam int REC_CYCLES    = 300;
  localparam int BP_FIRES      = FIFO_DEPTH + 4;
  localparam int SETTLE_CYCLES = 20;
  localparam int CSR_CYCLES    = 68;
  localparam int TEST_CYCLES   = OFF_CYCLES + 2 * REC_CYCLES + BP_FIRES
                                 + 6 * SETTLE_CYCLES + CSR_CYCLES;
  // Margin of four over the whole run
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

  localparam mode_csr_t MODE_OFF  = '{record_en: 1'b0, chan_mask: 2'b11};
  localparam mode_csr_t MODE_BOTH = '{record_en: 1'b1, chan_mask: 2'b11};
  // Bit 0 is ocl
  localparam mode_csr_t MODE_OCL  = '{record_en: 1'b1, chan_mask: 2'b01};

  logic                 clk;
  logic                 arst_n;
  axil_req_t            ocl_req;
  axil_rsp_t            ocl_rsp;
  axil_req_t            sda_req;
  axil_rsp_t            sda_rsp;
  axil_req_t            ocl_req_out;
  axil_rsp_t            ocl_rsp_out;
  axil_req_t            sda_req_out;
  axil_rsp_t            sda_rsp_out;
  logic                 trace_valid;
  trace_word_t          trace_word;
  logic                 trace_ready;
  logic                 cfg_we;
  logic [RR_ADDR_W-1:0] cfg_addr;
  logic [RR_DATA_W-1:0] cfg_wdata;
  logic [RR_DATA_W-1:0] cfg_rdata;

  integer      seed;
  int          errors;
  int          checks;
  // Words the reference expects the FIFO to accept
  int          queued;
  int          cycles;
  // Mode the merge is known to apply
  mode_csr_t   mode_eff;
  trace_word_t exp_q [$];
  logic        prev_stall;
  trace_word_t prev_word;

  rr_record_top #(
    .MODE_STAGES (MODE_STAGES),
    .FIFO_DEPTH  (FIFO_DEPTH)
  ) i_dut (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .i_ocl_req     (ocl_req),
    .o_ocl_req     (ocl_req_out),
    .i_ocl_rsp     (ocl_rsp),
    .o_ocl_rsp     (ocl_rsp_out),
    .i_sda_req     (sda_req),
    .o_sda_req     (sda_req_out),
    .i_sda_rsp     (sda_rsp),
    .o_sda_rsp     (sda_rsp_out),
    .o_trace_valid (trace_valid),
    .o_trace_word  (trace_word),
    .i_trace_ready (trace_ready),
    .i_cfg_we      (cfg_we),
    .i_cfg_addr    (cfg_addr),
    .i_cfg_wdata   (cfg_wdata),
    .o_cfg_rdata   (cfg_rdata)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check(input logic [CHECK_W-1:0] got, input logic [CHECK_W-1:0] exp,
                       input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  function automatic logic [31:0] rnd_word();
    rnd_word = $random(seed);
  endfunction

  // Shell side with valids and readies from one draw
  function automatic axil_req_t random_req();
    axil_req_t   r;
    logic [31:0] v;
    v = rnd_word();
    r.awvalid = v[3];
    r.wvalid  = v[7];
    r.bready  = v[11];
    r.arvalid = v[15];
    r.rready  = v[19];
    r.wstrb   = v[27:24];
    r.awaddr  = rnd_word();
    r.wdata   = rnd_word();
    r.araddr  = rnd_word();
    return r;
  endfunction

  // Simple CL responder with random readies and responses
  function automatic axil_rsp_t cl_response();
    axil_rsp_t   r;
    logic [31:0] v;
    v = rnd_word();
    r.awready = v[2];
    r.wready  = v[6];
    r.bvalid  = v[10];
    r.arready = v[14];
    r.rvalid  = v[18];
    r.bresp   = v[21:20];
    r.rresp   = v[25:24];
    r.rdata   = rnd_word();
    return r;
  endfunction

  // Expected log entry of one channel for one cycle
  function automatic chan_log_t chan_entry(input axil_req_t req, input axil_rsp_t rsp);
    chan_log_t e;
    e         = '0;
    e.aw_fire = req.awvalid && rsp.awready;
    e.w_fire  = req.wvalid && rsp.wready;
    e.b_fire  = rsp.bvalid && req.bready;
    e.ar_fire = req.arvalid && rsp.arready;
    e.r_fire  = rsp.rvalid && req.rready;
    e.valid   = e.aw_fire || e.w_fire || e.b_fire || e.ar_fire || e.r_fire;
    e.awaddr  = req.awaddr;
    e.wdata   = req.wdata;
    e.araddr  = req.araddr;
    e.rdata   = rsp.rdata;
    return e;
  endfunction

  // Reference model that returns 1 when the cycle yields a trace word
  function automatic logic expect_word(input axil_req_t ocl_rq, input axil_rsp_t ocl_rs,
                                       input axil_req_t sda_rq, input axil_rsp_t sda_rs,
                                       input mode_csr_t mode, output trace_word_t word);
    chan_log_t e [RR_NUM_CHAN];
    logic      hit;
    e[0] = chan_entry(ocl_rq, ocl_rs);
    e[1] = chan_entry(sda_rq, sda_rs);
    word = '0;
    hit  = 1'b0;
    for (int c = 0; c < RR_NUM_CHAN; c++) begin
      // Unrecorded channels stay zero in the word
      if (mode.record_en && mode.chan_mask[c] && e[c].valid) begin
        word.chan_valid[c] = 1'b1;
        word.entry[c]      = e[c];
        hit                = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic drive_idle();
    ocl_req = '0;
    ocl_rsp = '0;
    sda_req = '0;
    sda_rsp = '0;
  endtask

  // Random traffic where keep limits how many expected words are queued
  task automatic run_traffic(input int n, input logic force_fire, input int keep);
    trace_word_t w;
    int          pushed;
    pushed = 0;
    repeat (n) begin
      @(posedge clk);
      #1;
      ocl_req = random_req();
      ocl_rsp = cl_response();
      sda_req = random_req();
      sda_rsp = cl_response();
      if (force_fire) begin
        ocl_req.awvalid = 1'b1;
        ocl_rsp.awready = 1'b1;
      end
      if (expect_word(ocl_req, ocl_rsp, sda_req, sda_rsp, mode_eff, w)) begin
        if (pushed < keep) begin
          exp_q.push_back(w);
          queued++;
        end
        pushed++;
      end
    end
    @(posedge clk);
    #1;
    drive_idle();
  endtask

  task automatic write_csr(input logic [RR_ADDR_W-1:0] addr,
                           input logic [RR_DATA_W-1:0] data);
    @(posedge clk);
    #1;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  // Combinational read port sampled mid-cycle
  task automatic check_csr(input logic [RR_ADDR_W-1:0] addr,
                           input logic [RR_DATA_W-1:0] exp, input string msg);
    @(posedge clk);
    #1;
    cfg_addr = addr;
    #2;
    check(cfg_rdata, exp, msg);
  endtask

  // Channels are idle here so the wait covers the mode pipeline
  task automatic set_mode(input mode_csr_t m);
    write_csr(CSR_MODE_ADDR, RR_DATA_W'(m));
    mode_eff = m;
    repeat (10) @(posedge clk);
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (SETTLE_CYCLES) @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor and checker
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    trace_word_t exp_word;
    if (!arst_n) begin
      if (trace_valid) begin
        errors++;
        $display("Trace valid was high during reset at %0t ns", $time);
      end
      prev_stall = 1'b0;
    end else begin
      check(ocl_req_out, ocl_req, "ocl request pass-through");
      check(ocl_rsp_out, ocl_rsp, "ocl response pass-through");
      check(sda_req_out, sda_req, "sda request pass-through");
      check(sda_rsp_out, sda_rsp, "sda response pass-through");
      if (prev_stall) begin
        check({trace_valid, trace_word}, {1'b1, prev_word}, "trace held while stalled");
      end
      if (trace_valid && trace_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Trace word delivered at %0t ns when none was expected", $time);
        end else begin
          exp_word = exp_q.pop_front();
          check(trace_word, exp_word, "trace word");
        end
      end
      prev_stall = trace_valid && !trace_ready;
      prev_word  = trace_word;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d expected trace words still pending",
               TIMEOUT_CYCLES, exp_q.size());
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display(">>> FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    seed        = 32'h35ed732f;
    errors      = 0;
    checks      = 0;
    queued      = 0;
    cycles      = 0;
    mode_eff    = '0;
    prev_stall  = 1'b0;
    arst_n      = 1'b0;
    trace_ready = 1'b1;
    cfg_we      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    drive_idle();
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Reset mode and then record_en clear with both channels unmasked
    run_traffic(OFF_CYCLES / 2, 1'b0, OFF_CYCLES);
    set_mode(MODE_OFF);
    run_traffic(OFF_CYCLES / 2, 1'b0, OFF_CYCLES);
    drain();

    // Both channels recorded
    set_mode(MODE_BOTH);
    run_traffic(REC_CYCLES, 1'b0, REC_CYCLES);
    drain();

    // sda masked out
    set_mode(MODE_OCL);
    run_traffic(REC_CYCLES, 1'b0, REC_CYCLES);
    drain();

    // Sink stalled so only the first FIFO_DEPTH words survive
    set_mode(MODE_BOTH);
    check_csr(CSR_STATUS_ADDR, 32'h0, "overflow clear before stall");
    write_csr(CSR_DROPS_ADDR, 32'h0);
    @(posedge clk);
    #1;
    trace_ready = 1'b0;
    run_traffic(BP_FIRES, 1'b1, FIFO_DEPTH);
    repeat (SETTLE_CYCLES) @(posedge clk);
    check_csr(CSR_DROPS_ADDR, RR_DATA_W'(BP_FIRES - FIFO_DEPTH), "drop count");
    check_csr(CSR_STATUS_ADDR, 32'h1, "overflow flag set");
    @(posedge clk);
    #1;
    trace_ready = 1'b1;
    drain();

    // Register readback and clears
    check_csr(CSR_MODE_ADDR, RR_DATA_W'(MODE_BOTH), "mode readback");
    check_csr(CSR_WORDS_ADDR, RR_DATA_W'(queued), "accepted word count");
    write_csr(CSR_STATUS_ADDR, 32'h1);
    check_csr(CSR_STATUS_ADDR, 32'h0, "overflow cleared");
    write_csr(CSR_WORDS_ADDR, 32'h0);
    check_csr(CSR_WORDS_ADDR, 32'h0, "word count cleared");
    write_csr(CSR_DROPS_ADDR, 32'h5);
    check_csr(CSR_DROPS_ADDR, 32'h0, "drop count cleared");
    check_csr(32'h10, 32'h0, "unmapped read");
    drain();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/rr_axil_recorder.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_axil_recorder
  import rr_pkg::*;
(
  input  wire        i_clk,
  input  wire        i_arst_n,
  // From the shell
  input  axil_req_t  i_req,
  // From the CL
  input  axil_rsp_t  i_rsp,
  // Toward the CL
  output axil_req_t  o_req,
  // Toward the shell
  output axil_rsp_t  o_rsp,
  // Registered log entry
  output chan_log_t  o_log
);

  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;
  logic      ar_fire;
  logic      r_fire;
  chan_log_t log_d;

  //////////////////////////////////////////////////////////////////////
  // Pass-through
  //////////////////////////////////////////////////////////////////////
  // Zero latency in both directions
  assign o_req = i_req;
  assign o_rsp = i_rsp;

  //////////////////////////////////////////////////////////////////////
  // Handshake detection
  //////////////////////////////////////////////////////////////////////
  // Write address
  assign aw_fire = i_req.awvalid & i_rsp.awready;
  // Write data
  assign w_fire  = i_req.wvalid  & i_rsp.wready;
  // Write response, shell is the receiver
  assign b_fire  = i_rsp.bvalid  & i_req.bready;
  // Read address
  assign ar_fire = i_req.arvalid & i_rsp.arready;
  // Read data, shell is the receiver
  assign r_fire  = i_rsp.rvalid  & i_req.rready;

  always_comb begin
    log_d.aw_fire = aw_fire;
    log_d.w_fire  = w_fire;
    log_d.b_fire  = b_fire;
    log_d.ar_fire = ar_fire;
    log_d.r_fire  = r_fire;
    // Any handshake makes the cycle worth logging
    log_d.valid   = aw_fire | w_fire | b_fire | ar_fire | r_fire;
    // Payload as seen on the bus this cycle
    log_d.awaddr  = i_req.awaddr;
    log_d.wdata   = i_req.wdata;
    log_d.araddr  = i_req.araddr;
    log_d.rdata   = i_rsp.rdata;
  end

  // One stage, captured on the edge where the handshake fires
  rr_pipe #(
    .T      (chan_log_t),
    .STAGES (1)
  ) i_log_pipe (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_data   (log_d),
    .o_data   (o_log)
  );

endmodule

`default_nettype wire

/* verilog/rr_csrs.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_csrs
  import rr_pkg::*;
(
  input  wire                  i_clk,
  input  wire                  i_arst_n,
  input  wire                  i_cfg_we,
  input  wire  [RR_ADDR_W-1:0] i_cfg_addr,
  input  wire  [RR_DATA_W-1:0] i_cfg_wdata,
  output logic [RR_DATA_W-1:0] o_cfg_rdata,
  // Per-word events from the trace FIFO
  input  wire                  i_accept,
  input  wire                  i_drop,
  output mode_csr_t            o_mode
);

  logic                 overflow_q;
  logic [RR_DATA_W-1:0] words_q;
  logic [RR_DATA_W-1:0] drops_q;
  logic                 wr_mode;
  logic                 wr_status;
  logic                 wr_words;
  logic                 wr_drops;

  // Address decode
  assign wr_mode   = i_cfg_we & (i_cfg_addr == CSR_MODE_ADDR);
  assign wr_status = i_cfg_we & (i_cfg_addr == CSR_STATUS_ADDR);
  assign wr_words  = i_cfg_we & (i_cfg_addr == CSR_WORDS_ADDR);
  assign wr_drops  = i_cfg_we & (i_cfg_addr == CSR_DROPS_ADDR);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_mode     <= '0;
      overflow_q <= 1'b0;
      words_q    <= '0;
      drops_q    <= '0;
    end else begin
      if (wr_mode) begin
        o_mode <= mode_csr_t'(i_cfg_wdata[$bits(mode_csr_t)-1:0]);
      end
      // Sticky, a new drop wins over a clear in the same cycle
      if (i_drop) begin
        overflow_q <= 1'b1;
      end else if (wr_status && i_cfg_wdata[0]) begin
        overflow_q <= 1'b0;
      end
      // Counters clear on any write
      if (wr_words) begin
        words_q <= '0;
      end else if (i_accept) begin
        words_q <= words_q + RR_DATA_W'(1);
      end
      if (wr_drops) begin
        drops_q <= '0;
      end else if (i_drop) begin
        drops_q <= drops_q + RR_DATA_W'(1);
      end
    end
  end

  // Combinational read, unmapped returns zero
  always_comb begin
    case (i_cfg_addr)
      CSR_MODE_ADDR:   o_cfg_rdata = RR_DATA_W'(o_mode);
      CSR_STATUS_ADDR: o_cfg_rdata = RR_DATA_W'(overflow_q);
      CSR_WORDS_ADDR:  o_cfg_rdata = words_q;
      CSR_DROPS_ADDR:  o_cfg_rdata = drops_q;
      default:         o_cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/rr_log_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_log_merge
  import rr_pkg::*;
(
  input  wire          i_clk,
  input  wire          i_arst_n,
  input  chan_log_t    i_log_ocl,
  input  chan_log_t    i_log_sda,
  // Staged mode, same cycle for both channels
  input  mode_csr_t    i_mode,
  output logic         o_valid,
  output trace_word_t  o_word
);

  chan_log_t [RR_NUM_CHAN-1:0] chan_log;
  trace_word_t                 word_d;
  logic                        any_valid;

  // Pairwise join in merge order
  assign chan_log[0] = i_log_ocl;
  assign chan_log[1] = i_log_sda;

  // Record switch and channel mask
  always_comb begin
    for (int c = 0; c < RR_NUM_CHAN; c++) begin
      word_d.chan_valid[c] = chan_log[c].valid & i_mode.chan_mask[c] & i_mode.record_en;
      // Entry only carries data when its channel is recorded
      word_d.entry[c] = word_d.chan_valid[c] ? chan_log[c] : '0;
    end
  end

  assign any_valid = |word_d.chan_valid;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= any_valid;
    end
  end

  // Word register only loads on a recorded cycle
  always_ff @(posedge i_clk) begin
    if (any_valid) begin
      o_word <= word_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/rr_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_pipe #(
  parameter type T = logic [0:0],
  parameter int STAGES = 1
) (
  input  wire  i_clk,
  input  wire  i_arst_n,
  input  T     i_data,
  output T     o_data
);

  // Register chain, stage 0 takes the input
  T stage_q [STAGES];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int s = 0; s < STAGES; s++) begin
        stage_q[s] <= '0;
      end
    end else begin
      stage_q[0] <= i_data;
      for (int s = 1; s < STAGES; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  assign o_data = stage_q[STAGES-1];

endmodule

`default_nettype wire

/* verilog/rr_pkg.sv */
`default_nettype none

package rr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Channel geometry
  //////////////////////////////////////////////////////////////////////
  localparam int RR_ADDR_W = 32;
  localparam int RR_DATA_W = 32;
  // Merge order, 0 is ocl and 1 is sda
  localparam int RR_NUM_CHAN = 2;

  // Shell side of an AXI-Lite channel
  typedef struct packed {
    logic                   awvalid;
    logic [RR_ADDR_W-1:0]   awaddr;
    logic                   wvalid;
    logic [RR_DATA_W-1:0]   wdata;
    logic [RR_DATA_W/8-1:0] wstrb;
    logic                   bready;
    logic                   arvalid;
    logic [RR_ADDR_W-1:0]   araddr;
    logic                   rready;
  } axil_req_t;

  // CL side of an AXI-Lite channel
  typedef struct packed {
    logic                 awready;
    logic                 wready;
    logic                 bvalid;
    logic [1:0]           bresp;
    logic                 arready;
    logic                 rvalid;
    logic [RR_DATA_W-1:0] rdata;
    logic [1:0]           rresp;
  } axil_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Log and trace types
  //////////////////////////////////////////////////////////////////////
  // One cycle of one channel, valid is the OR of the fire bits
  typedef struct packed {
    logic                 valid;
    logic                 aw_fire;
    logic                 w_fire;
    logic                 b_fire;
    logic                 ar_fire;
    logic                 r_fire;
    logic [RR_ADDR_W-1:0] awaddr;
    logic [RR_DATA_W-1:0] wdata;
    logic [RR_ADDR_W-1:0] araddr;
    logic [RR_DATA_W-1:0] rdata;
  } chan_log_t;

  // Entry index follows the merge order
  typedef struct packed {
    logic [RR_NUM_CHAN-1:0]       chan_valid;
    chan_log_t [RR_NUM_CHAN-1:0]  entry;
  } trace_word_t;

  // Bit 2 record_en, bits 1:0 channel mask
  typedef struct packed {
    logic                   record_en;
    logic [RR_NUM_CHAN-1:0] chan_mask;
  } mode_csr_t;

  //////////////////////////////////////////////////////////////////////
  // CSR address map
  //////////////////////////////////////////////////////////////////////
  localparam logic [RR_ADDR_W-1:0] CSR_MODE_ADDR   = 32'h0;
  localparam logic [RR_ADDR_W-1:0] CSR_STATUS_ADDR = 32'h4;
  localparam logic [RR_ADDR_W-1:0] CSR_WORDS_ADDR  = 32'h8;
  localparam logic [RR_ADDR_W-1:0] CSR_DROPS_ADDR  = 32'hC;

endpackage

`default_nettype wire

/* verilog/rr_record_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_record_top
  import rr_pkg::*;
#(
  parameter int MODE_STAGES = 4,
  parameter int FIFO_DEPTH  = 8
) (
  input  wire                  i_clk,
  input  wire                  i_arst_n,
  // ocl channel
  input  axil_req_t            i_ocl_req,
  output axil_req_t            o_ocl_req,
  input  axil_rsp_t            i_ocl_rsp,
  output axil_rsp_t            o_ocl_rsp,
  // sda channel
  input  axil_req_t            i_sda_req,
  output axil_req_t            o_sda_req,
  input  axil_rsp_t            i_sda_rsp,
  output axil_rsp_t            o_sda_rsp,
  // Trace sink
  output logic                 o_trace_valid,
  output trace_word_t          o_trace_word,
  input  wire                  i_trace_ready,
  // CSR port
  input  wire                  i_cfg_we,
  input  wire  [RR_ADDR_W-1:0] i_cfg_addr,
  input  wire  [RR_DATA_W-1:0] i_cfg_wdata,
  output logic [RR_DATA_W-1:0] o_cfg_rdata
);

  chan_log_t   ocl_log;
  chan_log_t   sda_log;
  mode_csr_t   mode;
  // Mode as seen by the merge
  mode_csr_t   mode_q;
  logic        merge_valid;
  trace_word_t merge_word;
  logic        fifo_accept;
  logic        fifo_drop;

  //////////////////////////////////////////////////////////////////////
  // Channel recorders
  //////////////////////////////////////////////////////////////////////
  rr_axil_recorder i_ocl_recorder (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_req (i_ocl_req), .i_rsp (i_ocl_rsp),
    .o_req (o_ocl_req), .o_rsp (o_ocl_rsp),
    .o_log (ocl_log)
  );

  rr_axil_recorder i_sda_recorder (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_req (i_sda_req), .i_rsp (i_sda_rsp),
    .o_req (o_sda_req), .o_rsp (o_sda_rsp),
    .o_log (sda_log)
  );

  // Staged so both channels see a mode change together
  rr_pipe #(.T(mode_csr_t), .STAGES(MODE_STAGES)) i_mode_pipe (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_data (mode), .o_data (mode_q)
  );

  //////////////////////////////////////////////////////////////////////
  // Merge, FIFO and CSRs
  //////////////////////////////////////////////////////////////////////
  rr_log_merge i_merge (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_log_ocl (ocl_log), .i_log_sda (sda_log), .i_mode (mode_q),
    .o_valid (merge_valid), .o_word (merge_word)
  );

  rr_trace_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_valid (merge_valid), .i_word (merge_word),
    .o_trace_valid (o_trace_valid), .o_trace_word (o_trace_word),
    .i_trace_ready (i_trace_ready),
    .o_accept (fifo_accept), .o_drop (fifo_drop)
  );

  rr_csrs i_csrs (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_cfg_we (i_cfg_we), .i_cfg_addr (i_cfg_addr),
    .i_cfg_wdata (i_cfg_wdata), .o_cfg_rdata (o_cfg_rdata),
    .i_accept (fifo_accept), .i_drop (fifo_drop),
    .o_mode (mode)
  );

endmodule

`default_nettype wire

/* verilog/rr_trace_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_trace_fifo
  import rr_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  wire          i_clk,
  input  wire          i_arst_n,
  input  wire          i_valid,
  input  trace_word_t  i_word,
  output logic         o_trace_valid,
  output trace_word_t  o_trace_word,
  input  wire          i_trace_ready,
  output logic         o_accept,
  output logic         o_drop
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  trace_word_t      mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_nxt;
  // Words held, including the one shown at the output
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_left;
  logic             room;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign room       = (count != CNT_W'(FIFO_DEPTH));
  assign pop        = o_trace_valid & i_trace_ready;
  assign o_accept   = i_valid & room;
  // Full FIFO, the word is lost and the channels keep running
  assign o_drop     = i_valid & ~room;
  assign rd_ptr_nxt = pop ? ptr_inc(rd_ptr) : rd_ptr;
  // Words already in memory after this cycle's transfer
  assign count_left = count - CNT_W'(pop);

  //////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      o_trace_valid <= 1'b0;
    end else begin
      if (o_accept) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      rd_ptr <= rd_ptr_nxt;
      count  <= count_left + CNT_W'(o_accept);
      // Output register refills when empty or consumed
      if (!o_trace_valid || pop) begin
        o_trace_valid <= (count_left != '0);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage and registered read
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (o_accept) begin
      mem[wr_ptr] <= i_word;
    end
    // Holds steady while the sink stalls
    if (!o_trace_valid || pop) begin
      o_trace_word <= mem[rd_ptr_nxt];
    end
  end

endmodule

`default_nettype wire
